/* dwnld_pkg.sv */
/*
 * Shared definitions for the ROM download path.
 * Holds the HPS download index codes, the address widths and the two
 * payload types that travel through the pipeline stages. RTL and the
 * testbench checker refer to these by scoped name.
 */

package dwnld_pkg;

    // Download index codes as sent by the HPS
    localparam logic [7:0] ROM_INDEX = 8'd0;
    localparam logic [7:0] DIP_INDEX = 8'd254;

    // HPS byte address width
    localparam int HPS_AW = 27;

    // Word address width covering the whole HPS byte space
    localparam int WORD_AW = HPS_AW - 1;

    // Default SDRAM word address width
    localparam int SDRAMW_DEF = 23;

    // One ROM byte as it leaves the decode stage
    typedef struct packed {
        logic [HPS_AW-1:0] addr;
        logic [7:0]        data;
    } rom_byte_t;

    // One SDRAM programming write
    // Mask bits set mean the byte lane is not written
    typedef struct packed {
        logic [WORD_AW-1:0] addr;
        logic [15:0]        data;
        logic [1:0]         mask;
        logic [1:0]         ba;
    } prog_word_t;

endpackage

/* dwnld_stage.sv */
/*
 * Pipeline holding register with valid and stall.
 * The payload type is a parameter, so the same register carries the
 * decoded ROM bytes and the SDRAM write words. A new item is taken
 * whenever the register is empty or the next stage is not stalling.
 */

module dwnld_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_rom,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_item,
    output logic     ready,
    output logic     out_valid,
    output payload_t out_item,
    input  logic     stall
);

    // Load possible when empty or draining this cycle
    assign ready = ~out_valid | ~stall;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (ready) begin
            out_valid <= in_valid;
        end
    end

    // Item loads only when a valid item is taken
    always_ff @(posedge clk_rom) begin
        if (ready && in_valid) begin
            out_item <= in_item;
        end
    end

    // A stalled item stays in place until the next stage takes it
    hold_while_stalled: assert property (
        @(posedge clk_rom) disable iff (rst)
        (out_valid && stall) |=> (out_valid && $stable(out_item))
    ) else $error("stage item changed while stalled");

endmodule

/* dwnld_decode.sv */
/*
 * Decode stage of the ROM download path.
 * Each accepted HPS write is sorted by its download index. ROM data
 * becomes a byte item for the next holding register, DIP-switch data
 * is written into dipsw one byte lane at a time, anything else is
 * dropped. Also drives hps_wait and keeps the downloading level.
 */

module dwnld_decode (
    input  logic                      clk_rom,
    input  logic                      rst,
    // HPS download stream
    input  logic                      hps_download,
    input  logic [7:0]                hps_index,
    input  logic                      hps_wr,
    input  logic [dwnld_pkg::HPS_AW-1:0] hps_addr,
    input  logic [7:0]                hps_dout,
    // Pipeline status
    input  logic                      stage_ready,
    input  logic                      pipe_empty,
    // Item towards the first holding register
    output logic                      item_valid,
    output dwnld_pkg::rom_byte_t      item,
    // Level outputs
    output logic                      hps_wait,
    output logic [31:0]               dipsw,
    output logic                      downloading
);

    logic accepted;
    logic is_rom;
    logic is_dip;

    // Source waits while the first stage is full and stalled
    assign hps_wait = ~stage_ready;

    // Byte transferred on hps_wr with no wait
    assign accepted = hps_wr & ~hps_wait & hps_download;

    assign is_rom = hps_index == dwnld_pkg::ROM_INDEX;
    assign is_dip = hps_index == dwnld_pkg::DIP_INDEX;

    assign item_valid = accepted & is_rom;
    assign item       = '{addr: hps_addr, data: hps_dout};

    // DIP switch lane picked by the two low address bits
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            dipsw <= 32'd0;
        end else if (accepted && is_dip) begin
            dipsw[{hps_addr[1:0], 3'b000} +: 8] <= hps_dout;
        end
    end

    // Stays high until the last ROM byte has left both stages
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            downloading <= 1'b0;
        end else begin
            downloading <= hps_download | (downloading & ~pipe_empty);
        end
    end

    // Source must respect the wait level coming back from the stages
    no_wr_during_wait: assert property (
        @(posedge clk_rom) disable iff (rst)
        !(hps_wr && hps_wait)
    ) else $error("hps_wr pulsed while hps_wait was high");

endmodule

/* dwnld_bank_map.sv */
/*
 * Bank-mapping stage of the ROM download path.
 * Turns one ROM byte into an SDRAM word write. The image is split into
 * four banks by the start parameters; the bank is the highest one whose
 * start is at or below the word address and the written address is the
 * offset inside that bank. Purely combinational, it feeds the last
 * holding register that drives the prog_* ports.
 */

module dwnld_bank_map #(
    parameter int          SDRAMW    = dwnld_pkg::SDRAMW_DEF,
    parameter int unsigned BA1_START = 32'h0010_0000,
    parameter int unsigned BA2_START = 32'h0020_0000,
    parameter int unsigned BA3_START = 32'h0030_0000
) (
    input  dwnld_pkg::rom_byte_t  in_item,
    output dwnld_pkg::prog_word_t word
);

    localparam int AW = dwnld_pkg::WORD_AW;

    // Bank starts at word address width
    localparam logic [AW-1:0] BA1_W = AW'(BA1_START);
    localparam logic [AW-1:0] BA2_W = AW'(BA2_START);
    localparam logic [AW-1:0] BA3_W = AW'(BA3_START);

    // Keeps only the bits the SDRAM address bus can carry
    localparam logic [AW-1:0] SDRAM_MASK = AW'((64'd1 << SDRAMW) - 64'd1);

    logic [AW-1:0] word_addr;
    logic [AW-1:0] bank_base;
    logic [AW-1:0] offset;
    logic [1:0]    bank;

    // Two bytes per SDRAM word
    assign word_addr = in_item.addr[dwnld_pkg::HPS_AW-1:1];

    always_comb begin
        if (word_addr >= BA3_W) begin
            bank      = 2'd3;
            bank_base = BA3_W;
        end else if (word_addr >= BA2_W) begin
            bank      = 2'd2;
            bank_base = BA2_W;
        end else if (word_addr >= BA1_W) begin
            bank      = 2'd1;
            bank_base = BA1_W;
        end else begin
            bank      = 2'd0;
            bank_base = '0;
        end
    end

    assign offset = word_addr - bank_base;

    always_comb begin
        word.addr = offset & SDRAM_MASK;
        // Same byte on both lanes and the mask picks the one written
        word.data = {in_item.data, in_item.data};
        // Even byte goes to the low lane and odd byte to the high lane
        word.mask = in_item.addr[0] ? 2'b01 : 2'b10;
        word.ba   = bank;
    end

    // Bank layout checked at elaboration
    if (!(BA1_START < BA2_START && BA2_START < BA3_START)) begin : g_bad_banks
        $error("bank start addresses must be strictly increasing");
    end

    if (SDRAMW > AW) begin : g_bad_width
        $error("SDRAMW wider than the downloaded word address");
    end

endmodule

/* rom_dwnld.sv */
/*
 * ROM download path, top level.
 * The HPS byte stream goes through a decode stage and a bank-mapping
 * stage, each followed by a holding register, and comes out as SDRAM
 * programming writes. prog_we stays high until prog_rdy, and the
 * resulting back-pressure reaches the HPS as hps_wait.
 */

module rom_dwnld #(
    parameter int          SDRAMW    = dwnld_pkg::SDRAMW_DEF,
    parameter int unsigned BA1_START = 32'h0010_0000,
    parameter int unsigned BA2_START = 32'h0020_0000,
    parameter int unsigned BA3_START = 32'h0030_0000
) (
    input  logic                         clk_rom,
    input  logic                         rst,
    // HPS download stream
    input  logic                         hps_download,
    input  logic [7:0]                   hps_index,
    input  logic                         hps_wr,
    input  logic [dwnld_pkg::HPS_AW-1:0] hps_addr,
    input  logic [7:0]                   hps_dout,
    output logic                         hps_wait,
    output logic                         downloading,
    output logic [31:0]                  dipsw,
    // SDRAM programming
    output logic [SDRAMW-1:0]            prog_addr,
    output logic [15:0]                  prog_data,
    output logic [1:0]                   prog_mask,
    output logic [1:0]                   prog_ba,
    output logic                         prog_we,
    input  logic                         prog_rdy
);

    logic                  dec_valid;
    dwnld_pkg::rom_byte_t  dec_item;
    logic                  byte_ready;
    logic                  byte_valid;
    dwnld_pkg::rom_byte_t  byte_item;
    dwnld_pkg::prog_word_t map_word;
    logic                  prog_ready;
    dwnld_pkg::prog_word_t prog_word;
    logic                  pipe_empty;

    assign pipe_empty = ~byte_valid & ~prog_we;

    dwnld_decode u_decode (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .stage_ready  ( byte_ready   ),
        .pipe_empty   ( pipe_empty   ),
        .item_valid   ( dec_valid    ),
        .item         ( dec_item     ),
        .hps_wait     ( hps_wait     ),
        .dipsw        ( dipsw        ),
        .downloading  ( downloading  )
    );

    dwnld_stage #(.payload_t(dwnld_pkg::rom_byte_t)) u_byte_stage (
        .clk_rom   ( clk_rom     ),
        .rst       ( rst         ),
        .in_valid  ( dec_valid   ),
        .in_item   ( dec_item    ),
        .ready     ( byte_ready  ),
        .out_valid ( byte_valid  ),
        .out_item  ( byte_item   ),
        .stall     ( ~prog_ready )
    );

    dwnld_bank_map #(
        .SDRAMW    ( SDRAMW    ),
        .BA1_START ( BA1_START ),
        .BA2_START ( BA2_START ),
        .BA3_START ( BA3_START )
    ) u_bank_map (
        .in_item ( byte_item ),
        .word    ( map_word  )
    );

    // Last register holds the write until the SDRAM side takes it
    dwnld_stage #(.payload_t(dwnld_pkg::prog_word_t)) u_prog_stage (
        .clk_rom   ( clk_rom              ),
        .rst       ( rst                  ),
        .in_valid  ( byte_valid           ),
        .in_item   ( map_word             ),
        .ready     ( prog_ready           ),
        .out_valid ( prog_we              ),
        .out_item  ( prog_word            ),
        .stall     ( prog_we & ~prog_rdy  )
    );

    assign prog_addr = prog_word.addr[SDRAMW-1:0];
    assign prog_data = prog_word.data;
    assign prog_mask = prog_word.mask;
    assign prog_ba   = prog_word.ba;

endmodule

/* rom_dwnld_checker.sv */
/*
 * Checker for the ROM download path.
 * Watches the rom_dwnld ports at the falling clock edge, queues the
 * expected SDRAM write for every accepted ROM byte and compares the
 * writes, hps_wait, dipsw and downloading against the expected values.
 */

module rom_dwnld_checker #(
    parameter int          SDRAMW    = dwnld_pkg::SDRAMW_DEF,
    parameter int unsigned BA1_START = 16,
    parameter int unsigned BA2_START = 32,
    parameter int unsigned BA3_START = 48
) (
    input  logic                         clk_rom,
    input  logic                         rst,
    input  logic                         hps_download,
    input  logic [7:0]                   hps_index,
    input  logic                         hps_wr,
    input  logic [dwnld_pkg::HPS_AW-1:0] hps_addr,
    input  logic [7:0]                   hps_dout,
    input  logic                         hps_wait,
    input  logic                         downloading,
    input  logic [31:0]                  dipsw,
    input  logic [SDRAMW-1:0]            prog_addr,
    input  logic [15:0]                  prog_data,
    input  logic [1:0]                   prog_mask,
    input  logic [1:0]                   prog_ba,
    input  logic                         prog_we,
    input  logic                         prog_rdy,
    output int                           mismatches,
    output int                           failures,
    output int                           writes,
    output int                           pending
);

    timeunit 1ns;
    timeprecision 1ps;

    dwnld_pkg::prog_word_t expected_q[$];
    logic [31:0]           exp_dipsw;
    logic                  prev_dl_in;
    logic                  prev_dl;
    logic                  prev_busy;
    logic                  held;

    // Bank is the highest one starting at or below the word index
    function automatic dwnld_pkg::prog_word_t expected_word(
        input logic [dwnld_pkg::HPS_AW-1:0] addr,
        input logic [7:0]                   data
    );
        dwnld_pkg::prog_word_t w;
        int unsigned           starts [4];
        int unsigned           word_index;
        starts     = '{0, BA1_START, BA2_START, BA3_START};
        word_index = addr / 2;
        w.ba       = 2'd0;
        for (int b = 0; b < 4; b++) begin
            if (word_index >= starts[b]) begin
                w.ba = 2'(b);
            end
        end
        w.addr = dwnld_pkg::WORD_AW'(word_index - starts[w.ba]);
        w.data = {data, data};
        // Upper lane blocked for an even byte, lower lane for an odd one
        w.mask = {~addr[0], addr[0]};
        return w;
    endfunction

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] act
    );
        $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        mismatches++;
    endtask

    always @(negedge clk_rom) begin : compare
        dwnld_pkg::prog_word_t exp_word;
        logic                  exp_dl;
        logic                  exp_wait;
        logic                  accepted;
        if (rst) begin
            expected_q.delete();
            exp_dipsw  = '0;
            prev_dl_in = 1'b0;
            prev_dl    = 1'b0;
            prev_busy  = 1'b0;
            held       = 1'b0;
            mismatches = 0;
            failures   = 0;
            writes     = 0;
        end else begin
            exp_dl = prev_dl_in | (prev_dl & prev_busy);
            if (downloading !== exp_dl) report_mismatch("downloading", exp_dl, downloading);
            if (dipsw !== exp_dipsw) report_mismatch("dipsw", exp_dipsw, dipsw);
            // Two bytes in flight fill both stages
            exp_wait = (expected_q.size() == 2) && !prog_rdy;
            if (hps_wait !== exp_wait) report_mismatch("hps_wait", exp_wait, hps_wait);
            prev_busy  = expected_q.size() != 0;
            prev_dl_in = hps_download;
            prev_dl    = exp_dl;

            if (held && !prog_we) begin
                $display("ERROR at %0t ns: prog_we fell before prog_rdy", $time);
                failures++;
            end
            if (prog_we && expected_q.size() == 0) begin
                $display("ERROR at %0t ns: prog_we high with no ROM byte pending", $time);
                failures++;
            end else if (prog_we) begin
                exp_word = expected_q[0];
                if (prog_addr !== exp_word.addr[SDRAMW-1:0]) begin
                    report_mismatch("prog_addr", exp_word.addr[SDRAMW-1:0], prog_addr);
                end
                if (prog_data !== exp_word.data) begin
                    report_mismatch("prog_data", exp_word.data, prog_data);
                end
                if (prog_mask !== exp_word.mask) begin
                    report_mismatch("prog_mask", exp_word.mask, prog_mask);
                end
                if (prog_ba !== exp_word.ba) report_mismatch("prog_ba", exp_word.ba, prog_ba);
                if (prog_rdy) begin
                    void'(expected_q.pop_front());
                    writes++;
                end
            end
            held = prog_we && !prog_rdy;

            accepted = hps_wr && !hps_wait && hps_download;
            if (accepted && hps_index == dwnld_pkg::ROM_INDEX) begin
                expected_q.push_back(expected_word(hps_addr, hps_dout));
            end else if (accepted && hps_index == dwnld_pkg::DIP_INDEX) begin
                exp_dipsw[8*hps_addr[1:0] +: 8] = hps_dout;
            end
        end
        pending = expected_q.size();
    end

endmodule

/* tb_rom_dwnld.sv */
/*
 * Testbench for the ROM download path.
 * Sends a ROM image, a DIP-switch block and a block with an unknown index
 * into rom_dwnld while a random responder answers prog_we. The checker
 * module does the comparing and this module prints the result.
 */

module tb_rom_dwnld;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          SDRAMW          = dwnld_pkg::SDRAMW_DEF;
    localparam int          CLK_PERIOD      = 4;
    localparam int          ROM_BYTES       = 128;
    localparam int          BYTES_SENT      = ROM_BYTES + 8;
    localparam int          WATCHDOG_CYCLES = BYTES_SENT * 20 + 200;
    localparam logic [31:0] DIP_VALUE       = 32'h0F96_3CA5;

    logic                         clk_rom = 1'b0;
    logic                         rst;
    logic                         hps_download;
    logic [7:0]                   hps_index;
    logic                         hps_wr;
    logic [dwnld_pkg::HPS_AW-1:0] hps_addr;
    logic [7:0]                   hps_dout;
    logic                         hps_wait;
    logic                         downloading;
    logic [31:0]                  dipsw;
    logic [SDRAMW-1:0]            prog_addr;
    logic [15:0]                  prog_data;
    logic [1:0]                   prog_mask;
    logic [1:0]                   prog_ba;
    logic                         prog_we;
    logic                         prog_rdy;

    int     mismatches;
    int     failures;
    int     writes;
    int     pending;
    int     end_errors = 0;
    integer seed = 99774;
    int     rdy_wait;

    always #(CLK_PERIOD / 2) clk_rom = ~clk_rom;

    rom_dwnld #(
        .SDRAMW    ( SDRAMW ),
        .BA1_START ( 16     ),
        .BA2_START ( 32     ),
        .BA3_START ( 48     )
    ) UUT (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .hps_wait     ( hps_wait     ),
        .downloading  ( downloading  ),
        .dipsw        ( dipsw        ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .prog_ba      ( prog_ba      ),
        .prog_we      ( prog_we      ),
        .prog_rdy     ( prog_rdy     )
    );

    rom_dwnld_checker #(
        .SDRAMW    ( SDRAMW ),
        .BA1_START ( 16     ),
        .BA2_START ( 32     ),
        .BA3_START ( 48     )
    ) u_checker (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .hps_wait     ( hps_wait     ),
        .downloading  ( downloading  ),
        .dipsw        ( dipsw        ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .prog_ba      ( prog_ba      ),
        .prog_we      ( prog_we      ),
        .prog_rdy     ( prog_rdy     ),
        .mismatches   ( mismatches   ),
        .failures     ( failures     ),
        .writes       ( writes       ),
        .pending      ( pending      )
    );

    // SDRAM side answers each write after 0 to 3 cycles
    task automatic drive_rdy();
        if (!prog_we) begin
            prog_rdy = 1'b0;
        end else if (rdy_wait == 0) begin
            prog_rdy = 1'b1;
            rdy_wait = $unsigned($random(seed)) % 4;
        end else begin
            prog_rdy = 1'b0;
            rdy_wait = rdy_wait - 1;
        end
    endtask

    // One clock with inputs changed 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_rom);
        #1;
        hps_wr = 1'b0;
        drive_rdy();
    endtask

    task automatic send_byte(input logic [dwnld_pkg::HPS_AW-1:0] addr, input logic [7:0] data);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) tick();
        tick();
        // Hold off while the last stage is full and not draining
        while (prog_we && !prog_rdy) begin
            tick();
        end
        hps_addr = addr;
        hps_dout = data;
        hps_wr   = 1'b1;
    endtask

    task automatic end_download();
        tick();
        hps_download = 1'b0;
        while (downloading) begin
            tick();
        end
    endtask

    initial begin
        rst          = 1'b1;
        hps_download = 1'b0;
        hps_index    = 8'd0;
        hps_wr       = 1'b0;
        hps_addr     = '0;
        hps_dout     = 8'd0;
        prog_rdy     = 1'b0;
        rdy_wait     = $unsigned($random(seed)) % 4;
        repeat (5) @(posedge clk_rom);
        #1;
        rst = 1'b0;
        tick();

        // ROM image that crosses every bank start
        hps_index    = dwnld_pkg::ROM_INDEX;
        hps_download = 1'b1;
        for (int i = 0; i < ROM_BYTES; i++) begin
            send_byte(dwnld_pkg::HPS_AW'(i), 8'($random(seed)));
        end
        end_download();

        hps_index    = dwnld_pkg::DIP_INDEX;
        hps_download = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_byte(dwnld_pkg::HPS_AW'(i), DIP_VALUE[8*i +: 8]);
        end
        end_download();

        // Unknown index leaves dipsw and prog_we alone
        hps_index    = 8'd7;
        hps_download = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_byte(dwnld_pkg::HPS_AW'(i), 8'hFF);
        end
        end_download();
        repeat (10) tick();

        if (writes != ROM_BYTES) begin
            $display("ERROR: %0d SDRAM writes seen for %0d ROM bytes sent", writes, ROM_BYTES);
            end_errors++;
        end
        if (pending != 0) begin
            $display("ERROR: %0d ROM bytes were never written to SDRAM", pending);
            end_errors++;
        end
        if (dipsw !== DIP_VALUE) begin
            $display("MISMATCH at %0t ns: dipsw expected %h, got %h", $time, DIP_VALUE, dipsw);
            end_errors++;
        end
        $display("Error counts: %0d mismatches, %0d other failures, %0d end-of-run failures",
                 mismatches, failures, end_errors);
        if (mismatches + failures + end_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the number of bytes sent
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* flist.f */
dwnld_pkg.sv
dwnld_stage.sv
dwnld_decode.sv
dwnld_bank_map.sv
rom_dwnld.sv
rom_dwnld_checker.sv
tb_rom_dwnld.sv

/* Bender.yml */
package:
  name: rom_dwnld

sources:
  - dwnld_pkg.sv
  - dwnld_stage.sv
  - dwnld_decode.sv
  - dwnld_bank_map.sv
  - rom_dwnld.sv
  - target: simulation
    files:
      - rom_dwnld_checker.sv
      - tb_rom_dwnld.sv
